/* build.f */
+incdir+hdl
hdl/pokey_io_pkg.sv
hdl/pokey_io_if.sv
hdl/key_scanner.sv
hdl/pot_timer.sv
hdl/io_read_mux.sv
hdl/pokey_io_top.sv
tb/pokey_io_asserts.sv
tb/pokey_io_tb.sv

/* hdl/io_read_mux.sv */
// cpu read port decode
`timescale 1ns/10ps
`include "pokey_io_consts.svh"

module io_read_mux (
    input  logic       rd,        // read strobe, one cycle
    input  logic [3:0] addr,
    output logic [7:0] data_out,  // valid whenever addr is, no register
    pokey_io_if.reader io
);

    logic sel_pot;                // addr in pot0..pot7
    logic sel_allpot;
    logic sel_kbcode;

    assign sel_pot    = (addr <= `ADDR_POT_LAST);
    assign sel_allpot = (addr == `ADDR_ALLPOT);
    assign sel_kbcode = (addr == `ADDR_KBCODE);

    // read of kbcode acknowledges the key, irq drops in key_scanner
    assign io.kbcode_rd = rd & sel_kbcode;

    always_comb begin
        data_out = 8'h00;  // unused addresses
        if (sel_pot)
            data_out = io.pots[addr[2:0]];
        else if (sel_allpot)
            data_out = io.allpot;
        else if (sel_kbcode)
            data_out = io.kbcode.raw;  // byte view of the keycode
    end

endmodule

/* hdl/key_scanner.sv */
// keyboard matrix scanner
`timescale 1ns/10ps
`include "pokey_io_consts.svh"

module key_scanner (
    input  logic       o2,
    input  logic       rst_n,
    input  logic       kr1_L,      // matrix return, low on pressed key
    input  logic       kr2_L,      // shift return
    output logic [5:0] key_scan_L, // inverted scan count to the matrix
    pokey_io_if.key_src io
);

    logic [5:0] scan_cnt;          // free running, one key per cycle
    logic [5:0] cnt_d1;            // scan count lined up with sync stage 1
    logic [5:0] cnt_d2;            // lined up with sync stage 2
    logic [1:0] kr1_sync;
    logic [1:0] kr2_sync;
    logic       hit;               // key seen at cnt_d2
    logic       shift_now;         // shift held at the same moment
    logic       pass_end;          // last key of a pass in the aligned domain
    logic       seen_pass;         // some key seen so far this pass
    logic       cand_valid;
    logic [5:0] cand_key;          // key seen on the previous pass
    logic       key_held;          // accepted key not yet released
    logic       irq_q;
    pokey_io_pkg::kbcode_u kbcode_q;

    assign key_scan_L = ~scan_cnt;
    assign hit        = ~kr1_sync[1];
    assign shift_now  = ~kr2_sync[1];
    assign pass_end   = (cnt_d2 == 6'(`KEY_COUNT - 1));

    assign io.kbcode  = kbcode_q;
    assign io.key_irq = irq_q;

    always_ff @(posedge o2 or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt   <= '0;
            cnt_d1     <= '0;
            cnt_d2     <= '0;
            kr1_sync   <= 2'b11;   // returns idle high
            kr2_sync   <= 2'b11;
            seen_pass  <= 1'b0;
            cand_valid <= 1'b0;
            cand_key   <= '0;
            key_held   <= 1'b0;
            irq_q      <= 1'b0;
            kbcode_q   <= '0;
        end else begin
            scan_cnt <= scan_cnt + 6'd1;  // wraps after 63
            cnt_d1   <= scan_cnt;
            cnt_d2   <= cnt_d1;
            kr1_sync <= {kr1_sync[0], kr1_L};
            kr2_sync <= {kr2_sync[0], kr2_L};

            // cpu read clears the irq, a key accepted in the same cycle sets it again
            if (io.kbcode_rd)
                irq_q <= 1'b0;

            if (hit) begin
                if (cand_valid && (cand_key == cnt_d2)) begin
                    // same key on two passes in a row
                    if (!key_held) begin
                        kbcode_q.fields.zero  <= 1'b0;
                        kbcode_q.fields.shift <= shift_now;
                        kbcode_q.fields.key   <= cnt_d2;  // overwrites a pending key
                        irq_q                 <= 1'b1;
                        key_held              <= 1'b1;
                    end
                end else begin
                    // new candidate, must show up again next pass
                    cand_key   <= cnt_d2;
                    cand_valid <= 1'b1;
                end
            end

            // pass bookkeeping
            if (pass_end) begin
                seen_pass <= 1'b0;
                if (!(seen_pass || hit)) begin
                    // a full pass with no key, matrix released
                    cand_valid <= 1'b0;
                    key_held   <= 1'b0;
                end
            end else if (hit) begin
                seen_pass <= 1'b1;
            end
        end
    end

endmodule

/* hdl/pokey_io_consts.svh */
// pokey i/o constants
`ifndef POKEY_IO_CONSTS_SVH
`define POKEY_IO_CONSTS_SVH

// paddle sweep
// one line count per hline pulse, pots still open at the
// last line are closed with this value
`define POT_LINES 8'd228      // last line of a sweep, also the max pot reading

// keyboard matrix
`define KEY_COUNT 64          // keys per scan pass, 6-bit scan counter

// read port map
// 0..7 are pot0..pot7, selected by addr[2:0]
`define ADDR_POT_LAST 4'd7    // highest pot address
`define ADDR_ALLPOT   4'd8    // one bit per pot still measuring
`define ADDR_KBCODE   4'd9    // last debounced key, read clears key_irq

// 10..15 unused, read as zero

`endif

/* hdl/pokey_io_if.sv */
// pokey i/o capture bus
`timescale 1ns/10ps

interface pokey_io_if (
    input logic o2  // all signals change on the rising edge of o2
);

    pokey_io_pkg::pot_array_t pots;      // latched pot counts
    logic [7:0]               allpot;    // 1 = pot still measuring
    pokey_io_pkg::kbcode_u    kbcode;    // last accepted key
    logic                     key_irq;   // level, new key pending
    logic                     kbcode_rd; // cpu read of kbcode, one cycle

    // keyboard stage
    modport key_src (
        input  o2,
        output kbcode,
        output key_irq,
        input  kbcode_rd
    );

    // paddle stage
    modport pot_src (
        input  o2,
        output pots,
        output allpot
    );

    // cpu read stage
    modport reader (
        input  o2,
        input  pots,
        input  allpot,
        input  kbcode,
        input  key_irq,
        output kbcode_rd
    );

endinterface

/* hdl/pokey_io_pkg.sv */
// pokey i/o types
package pokey_io_pkg;

    // keycode as the scanner builds it
    // bit 7 is always zero here, the real chip puts the
    // control key in it and that key is not scanned
    typedef struct packed {
        logic       zero;   // unused control key position
        logic       shift;  // kr2 low at the moment of the key hit
        logic [5:0] key;    // scan count where kr1 went low
    } kbcode_fields_t;

    // one byte, two views
    // fields on the write side, raw on the cpu read side
    typedef union packed {
        logic [7:0]     raw;     // byte as returned on data_out
        kbcode_fields_t fields;  // decoded view
    } kbcode_u;

    // eight pot counts, pot i in element i
    typedef logic [7:0][7:0] pot_array_t;

endpackage

/* hdl/pokey_io_top.sv */
// pokey i/o control top
`timescale 1ns/10ps

module pokey_io_top (
    input  logic       o2,          // system clock
    input  logic       rst_n,
    // paddles
    input  logic       hline,       // line pulse from video timing
    input  logic       potgo,       // sweep start strobe
    input  logic [7:0] pot_scan,    // pot comparator lines
    // keyboard
    input  logic       kr1_L,
    input  logic       kr2_L,
    output logic [5:0] key_scan_L,
    // cpu read
    input  logic       rd,
    input  logic [3:0] addr,
    output logic [7:0] data_out,
    output logic       key_irq      // level, cleared by reading kbcode
);

    // captured values, capture stages to read stage
    pokey_io_if io_i (
        .o2 (o2)
    );

    // keyboard capture
    key_scanner key_i (
        .o2         (o2),
        .rst_n      (rst_n),
        .kr1_L      (kr1_L),
        .kr2_L      (kr2_L),
        .key_scan_L (key_scan_L),
        .io         (io_i.key_src)
    );

    // paddle capture
    pot_timer pot_i (
        .o2       (o2),
        .rst_n    (rst_n),
        .hline    (hline),
        .potgo    (potgo),
        .pot_scan (pot_scan),
        .io       (io_i.pot_src)
    );

    // read port
    io_read_mux mux_i (
        .rd       (rd),
        .addr     (addr),
        .data_out (data_out),
        .io       (io_i.reader)
    );

    assign key_irq = io_i.key_irq;  // straight from the scanner register

endmodule

/* hdl/pot_timer.sv */
// paddle pot timer
`timescale 1ns/10ps
`include "pokey_io_consts.svh"

module pot_timer (
    input  logic       o2,
    input  logic       rst_n,
    input  logic       hline,     // one pulse per tv line
    input  logic       potgo,     // start a new sweep
    input  logic [7:0] pot_scan,  // comparator outputs, rise when cap is charged
    pokey_io_if.pot_src io
);

    logic [7:0] scan_sync1;
    logic [7:0] scan_sync2;
    logic [7:0] scan_prev;        // sync stage 2 one cycle back
    logic [7:0] rise;             // synchronized rising edge per pot
    logic [7:0] line_cnt;         // lines since potgo
    logic       sweep;            // sweep in progress
    logic       at_limit;
    logic [7:0] allpot_q;
    pokey_io_pkg::pot_array_t pots_q;

    assign rise     = scan_sync2 & ~scan_prev;
    assign at_limit = (line_cnt == `POT_LINES);

    assign io.pots   = pots_q;
    assign io.allpot = allpot_q;

    // two flop sync plus edge history, runs all the time
    always_ff @(posedge o2 or negedge rst_n) begin
        if (!rst_n) begin
            scan_sync1 <= '0;
            scan_sync2 <= '0;
            scan_prev  <= '0;
        end else begin
            scan_sync1 <= pot_scan;
            scan_sync2 <= scan_sync1;
            scan_prev  <= scan_sync2;
        end
    end

    always_ff @(posedge o2 or negedge rst_n) begin
        if (!rst_n) begin
            line_cnt <= '0;
            sweep    <= 1'b0;   // idle until the first potgo
            allpot_q <= '0;
            pots_q   <= '0;
        end else if (potgo) begin
            // restart, potgo wins over anything in flight
            line_cnt <= '0;
            sweep    <= 1'b1;
            allpot_q <= 8'hff;
            pots_q   <= '0;
        end else if (sweep) begin
            if (at_limit) begin
                // close whatever is still open at the last line
                for (int i = 0; i < 8; i++) begin
                    if (allpot_q[i])
                        pots_q[i] <= `POT_LINES;
                end
                allpot_q <= '0;
                sweep    <= 1'b0;  // count stays at the limit
            end else begin
                for (int i = 0; i < 8; i++) begin
                    // only the first rise of a pot counts
                    if (rise[i] && allpot_q[i]) begin
                        pots_q[i]   <= line_cnt;
                        allpot_q[i] <= 1'b0;
                    end
                end
                if (hline)
                    line_cnt <= line_cnt + 8'd1;
            end
        end
    end

endmodule

/* tb/pokey_io_asserts.sv */
// pokey i/o bound checks
`timescale 1ns/10ps
`include "pokey_io_consts.svh"

module pokey_io_asserts (
    input logic       o2,
    input logic       rst_n,
    input logic [5:0] key_scan_L,
    input logic       key_irq,
    input logic [3:0] addr,
    input logic [7:0] data_out
);

    int         assert_fails = 0;  // failed assertion count
    logic [5:0] scan_cnt;

    assign scan_cnt = ~key_scan_L;  // matrix lines run inverted

    // one key per cycle, 63 wraps to 0
    scan_steps: assert property (
        @(posedge o2) disable iff (!rst_n)
        $past(rst_n) |-> (scan_cnt == $past(scan_cnt) + 6'd1)
    ) else begin
        $error("key_scan_L did not advance by one key");
        assert_fails++;
    end

    // no pending key while in reset
    irq_in_reset: assert property (
        @(posedge o2) !rst_n |-> !key_irq
    ) else begin
        $error("key_irq high during reset");
        assert_fails++;
    end

    // addresses above kbcode are holes in the map
    unused_reads_zero: assert property (
        @(posedge o2) disable iff (!rst_n)
        (addr > `ADDR_KBCODE) |-> (data_out == 8'h00)
    ) else begin
        $error("nonzero data_out at unused address %0d", addr);
        assert_fails++;
    end

endmodule

bind pokey_io_top pokey_io_asserts asserts_i (
    .o2         (o2),
    .rst_n      (rst_n),
    .key_scan_L (key_scan_L),
    .key_irq    (key_irq),
    .addr       (addr),
    .data_out   (data_out)
);

/* tb/pokey_io_tb.sv */
// pokey i/o testbench
`timescale 1ns/10ps
`include "pokey_io_consts.svh"

module pokey_io_tb;

    localparam int MAX_TESTS  = 32;
    localparam int RAND_TESTS = 3;      // extra pot sweeps after the file
    localparam logic [31:0] SEED = 32'd43278;

    logic       o2;
    logic       rst_n;
    logic       hline;
    logic       potgo;
    logic [7:0] pot_scan;
    logic       kr1_L;
    logic       kr2_L;
    logic       rd;
    logic [3:0] addr;
    logic [5:0] key_scan_L;
    logic [7:0] data_out;
    logic       key_irq;

    // keyboard matrix model
    logic       key_on;                 // a key is held down
    logic [5:0] key_sel;                // which one
    logic       key_shift;

    // test table filled from the data file and the generator
    logic        t_is_key [MAX_TESTS];
    int          t_key [MAX_TESTS];
    int          t_shift [MAX_TESTS];
    int          t_exp_kb [MAX_TESTS];
    int          t_close [MAX_TESTS][8];    // 255 = never closes
    int          t_exp_pot [MAX_TESTS][8];
    int          t_mid [MAX_TESTS];         // line of the mid sweep allpot check
    int          t_exp_mid [MAX_TESTS];
    int          n_tests;
    int          n_run;
    int          n_failed;
    int          n_errors;
    bit          loaded;
    logic [31:0] rand_state;

    pokey_io_top dut_i (
        .o2         (o2),
        .rst_n      (rst_n),
        .hline      (hline),
        .potgo      (potgo),
        .pot_scan   (pot_scan),
        .kr1_L      (kr1_L),
        .kr2_L      (kr2_L),
        .rd         (rd),
        .addr       (addr),
        .key_scan_L (key_scan_L),
        .data_out   (data_out),
        .key_irq    (key_irq)
    );

    // return line low while the scan hits the held key
    assign kr1_L = !(key_on && (~key_scan_L == key_sel));
    assign kr2_L = !(key_on && key_shift);  // shift held with the key

    initial begin
        o2 = 1'b0;
        forever #5 o2 = ~o2;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
            n_errors++;
        end
    endtask

    // one cpu read with data sampled mid cycle
    task automatic read_reg(input logic [3:0] a, input logic strobe, output logic [7:0] value);
        @(posedge o2);
        addr <= a;
        rd   <= strobe;
        @(negedge o2);
        value = data_out;
        @(posedge o2);
        rd <= 1'b0;
    endtask

    task automatic finish_test(input string what, input int errs_before);
        n_run++;
        if (n_errors == errs_before) begin
            $display("test %0d %s: ok", n_run, what);
        end else begin
            n_failed++;
            $display("test %0d %s: failed", n_run, what);
        end
    endtask

    task automatic load_tests();
        int               fd;
        int               code;
        int               i;
        logic [8*16-1:0]  word;
        logic [8*256-1:0] rest;
        fd = $fopen("tb/pokey_io_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/pokey_io_tests.txt, file tests not run");
            n_errors++;
        end else begin
            code = $fscanf(fd, "%s", word);
            while (code == 1) begin
                if (word == "#") begin
                    code = $fgets(rest, fd);  // comment line
                end else if (word == "key" && n_tests < MAX_TESTS) begin
                    t_is_key[n_tests] = 1'b1;
                    code = $fscanf(fd, "%d %d %h", t_key[n_tests], t_shift[n_tests],
                                   t_exp_kb[n_tests]);
                    n_tests++;
                end else if (word == "pot" && n_tests < MAX_TESTS) begin
                    t_is_key[n_tests] = 1'b0;
                    for (i = 0; i < 8; i++)
                        code = $fscanf(fd, "%d", t_close[n_tests][i]);
                    for (i = 0; i < 8; i++)
                        code = $fscanf(fd, "%d", t_exp_pot[n_tests][i]);
                    code = $fscanf(fd, "%d %h", t_mid[n_tests], t_exp_mid[n_tests]);
                    n_tests++;
                end else begin
                    $display("unknown or extra entry in the test file, line skipped");
                    n_errors++;
                    code = $fgets(rest, fd);
                end
                code = $fscanf(fd, "%s", word);
            end
            $fclose(fd);
        end
    endtask

    // random sweeps with expected values from the pot rules
    task automatic add_random_tests();
        int j;
        int i;
        int c;
        for (j = 0; j < RAND_TESTS && n_tests < MAX_TESTS; j++) begin
            t_is_key[n_tests]  = 1'b0;
            rand_state         = lcg_step(rand_state);
            t_mid[n_tests]     = (rand_state >> 8) % `POT_LINES;
            t_exp_mid[n_tests] = 0;
            for (i = 0; i < 8; i++) begin
                rand_state = lcg_step(rand_state);
                c = (rand_state >> 8) % 240;
                if (c >= `POT_LINES)
                    c = 255;                  // left open and closed at the limit
                t_close[n_tests][i]   = c;
                t_exp_pot[n_tests][i] = (c < `POT_LINES) ? c : `POT_LINES;
                if (c > t_mid[n_tests])
                    t_exp_mid[n_tests] |= (1 << i);  // still open at the mid check
            end
            n_tests++;
        end
    endtask

    task automatic verify_reset_state();
        int         errs_before;
        int         i;
        logic [7:0] value;
        errs_before = n_errors;
        check_value("key_irq", {7'b0, key_irq}, 8'h00);
        for (i = 0; i < 8; i++) begin
            read_reg(4'(i), 1'b0, value);
            check_value($sformatf("data_out (pot%0d)", i), value, 8'h00);
        end
        read_reg(`ADDR_ALLPOT, 1'b0, value);
        check_value("data_out (allpot)", value, 8'h00);
        finish_test("after reset", errs_before);
    endtask

    task automatic press_and_release_key(input int idx);
        int         errs_before;
        int         waited;
        logic       retrig;
        logic [7:0] value;
        errs_before = n_errors;
        @(posedge o2);
        key_sel   <= 6'(t_key[idx]);
        key_shift <= (t_shift[idx] != 0);
        key_on    <= 1'b1;
        waited = 0;
        while (!key_irq && waited < 4 * `KEY_COUNT) begin
            @(negedge o2);
            waited++;
        end
        if (!key_irq) begin
            $display("key %0d was never reported, key_irq stayed low", t_key[idx]);
            n_errors++;
        end
        read_reg(`ADDR_KBCODE, 1'b1, value);  // read acknowledges the key
        check_value("data_out (kbcode)", value, 8'(t_exp_kb[idx]));
        @(negedge o2);
        check_value("key_irq after read", {7'b0, key_irq}, 8'h00);
        retrig = 1'b0;
        repeat (3 * `KEY_COUNT) begin     // key still held so irq must stay quiet
            @(negedge o2);
            if (key_irq)
                retrig = 1'b1;
        end
        check_value("key_irq while held", {7'b0, retrig}, 8'h00);
        @(posedge o2);
        key_on <= 1'b0;
        repeat (3 * `KEY_COUNT) @(posedge o2);  // released for more than a pass
        finish_test($sformatf("key %0d shift %0d", t_key[idx], t_shift[idx]), errs_before);
    endtask

    task automatic sweep_pots(input int idx);
        int         errs_before;
        int         line;
        int         i;
        logic [7:0] scan_bits;
        logic [7:0] value;
        logic [7:0] exp;
        errs_before = n_errors;
        scan_bits   = '0;
        @(posedge o2);
        pot_scan <= '0;
        repeat (4) @(posedge o2);     // drain the synchronizers
        potgo <= 1'b1;
        @(posedge o2);
        potgo <= 1'b0;
        read_reg(`ADDR_ALLPOT, 1'b0, value);
        check_value("data_out (allpot after potgo)", value, 8'hff);
        for (i = 0; i < 8; i++) begin
            read_reg(4'(i), 1'b0, value);
            check_value($sformatf("data_out (pot%0d after potgo)", i), value, 8'h00);
        end
        addr <= `ADDR_ALLPOT;         // watch allpot through the sweep
        for (line = 0; line < `POT_LINES; line++) begin
            for (i = 0; i < 8; i++) begin
                if (t_close[idx][i] == line)
                    scan_bits[i] = 1'b1;  // cap charged on this line
            end
            pot_scan <= scan_bits;
            repeat (3) @(posedge o2);
            hline <= 1'b1;
            @(negedge o2);
            if (line == t_mid[idx])
                check_value("data_out (allpot mid sweep)", data_out, 8'(t_exp_mid[idx]));
            @(posedge o2);
            hline <= 1'b0;
        end
        repeat (4) @(posedge o2);     // limit reached and open pots closed
        for (i = 0; i < 8; i++) begin
            read_reg(4'(i), 1'b0, value);
            exp = 8'(t_exp_pot[idx][i]);
            if (exp < `POT_LINES && value == exp + 8'd1)
                exp = value;              // one line of synchronizer slack
            check_value($sformatf("data_out (pot%0d)", i), value, exp);
        end
        read_reg(`ADDR_ALLPOT, 1'b0, value);
        check_value("data_out (allpot at end)", value, 8'h00);
        finish_test($sformatf("pot sweep %0d", idx), errs_before);
    endtask

    task automatic read_unused_addrs();
        int         errs_before;
        int         a;
        logic [7:0] value;
        errs_before = n_errors;
        for (a = `ADDR_KBCODE + 1; a < 16; a++) begin
            read_reg(4'(a), 1'b0, value);
            check_value($sformatf("data_out (addr %0d)", a), value, 8'h00);
        end
        finish_test("unused addresses", errs_before);
    endtask

    initial begin : main
        int i;
        rst_n      = 1'b0;
        hline      = 1'b0;
        potgo      = 1'b0;
        pot_scan   = '0;
        rd         = 1'b0;
        addr       = '0;
        key_on     = 1'b0;
        key_sel    = '0;
        key_shift  = 1'b0;
        n_tests    = 0;
        n_run      = 0;
        n_failed   = 0;
        n_errors   = 0;
        rand_state = SEED;
        load_tests();
        add_random_tests();
        loaded = 1'b1;
        repeat (5) @(posedge o2);
        rst_n <= 1'b1;
        @(posedge o2);
        verify_reset_state();
        for (i = 0; i < n_tests; i++) begin
            if (t_is_key[i])
                press_and_release_key(i);
            else
                sweep_pots(i);
        end
        read_unused_addrs();
        n_errors += dut_i.asserts_i.assert_fails;
        $display("tests run %0d, failed %0d, errors %0d", n_run, n_failed, n_errors);
        if (n_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // run length bound from the number of tests
    initial begin : watchdog
        int budget;
        wait (loaded);
        budget = (n_tests + 2) * (2 * `KEY_COUNT * 3 + (`POT_LINES + 4) * 4) + 2000;
        repeat (budget) @(posedge o2);
        $display("timeout: the run did not finish within %0d cycles", budget);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* tb/pokey_io_tests.txt */
# key <key number 0..63> <shift 0/1> <expected kbcode, hex>
# pot <close line of pot0..pot7, 255 = never> <expected pot0..pot7> <mid line> <allpot at mid, hex>

# single keys, each one replaces the code of the key before it
key 12 0 0c
key 45 1 6d
key  0 0 00
key 63 1 7f
key  7 1 47
key 33 0 21
key 12 1 4c

# even spread, three pots closed at the mid check
pot  10  20  30  40  50  60  70  80    10  20  30  40  50  60  70  80    35 f8

# nothing ever closes, all read the last line
pot 255 255 255 255 255 255 255 255   228 228 228 228 228 228 228 228   100 ff

# first and last line, a shared line and one open pot
pot   0 227   5 255 100 100   1 200     0 227   5 228 100 100   1 200   100 8a

# mixed order, mid check on a close line
pot 150   3 255  90  12 255 226  64   150   3 228  90  12 228 226  64    64 6d

# everything closes early
pot   1   2   3   4   5   6   7   8     1   2   3   4   5   6   7   8   200 00
